// File: sparse_dot_unit.f
src/sparse_pkg.sv
src/operand_store.sv
src/match_scanner.sv
src/join_control.sv
src/pair_fifo.sv
src/mac_accumulator.sv
src/sparse_dot_unit.sv
verification/sparse_dot_unit_assert.sv
verification/tb_sparse_dot_unit.sv

// File: src/join_control.sv
`timescale 1ns/1ps

module join_control (
    input  logic clk,
    input  logic rst_n,
    input  logic start_compute,
    input  logic scan_empty,
    input  logic match_valid,
    input  logic fifo_empty,
    input  logic pair_valid,
    input  logic mac_busy,
    output logic clear_scan,
    output logic clear_sum,
    output logic done_compute
);

    sparse_pkg::ctrl_state_e state;
    sparse_pkg::ctrl_state_e next_state;
    logic                    start_accept;
    logic                    pipe_quiet;

    // Start is only taken from IDLE
    assign start_accept = (state == sparse_pkg::IDLE) && start_compute;
    assign clear_scan   = start_accept;
    assign clear_sum    = start_accept;

    // Nothing left in the scanner, FIFO or MAC
    assign pipe_quiet = scan_empty && !match_valid && fifo_empty && !pair_valid && !mac_busy;

    always_comb begin
        next_state = state;
        case (state)
            sparse_pkg::IDLE:    if (start_accept) next_state = sparse_pkg::PROCESS;
            sparse_pkg::PROCESS: if (pipe_quiet) next_state = sparse_pkg::DONE;
            sparse_pkg::DONE:    next_state = sparse_pkg::IDLE;
            default:             next_state = sparse_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= sparse_pkg::IDLE;
            done_compute <= 1'b0;
        end else begin
            state        <= next_state;
            done_compute <= (state == sparse_pkg::DONE);
        end
    end

endmodule

// File: src/mac_accumulator.sv
`timescale 1ns/1ps

module mac_accumulator (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               clear_sum,
    input  logic                               pair_valid,
    input  sparse_pkg::pair_t                  pair,
    output logic [sparse_pkg::ACCUM_WIDTH-1:0] partial_sum,
    output logic                               mac_busy
);

    logic [2*sparse_pkg::DATA_WIDTH-1:0] product;

    // Unsigned 8x8 product, zero-extended into the sum
    assign product  = pair.filter_value * pair.feature_value;
    assign mac_busy = pair_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            partial_sum <= '0;
        end else if (clear_sum) begin
            partial_sum <= '0;
        end else if (pair_valid) begin
            partial_sum <= partial_sum + product;
        end
    end

endmodule

// File: src/match_scanner.sv
`timescale 1ns/1ps

module match_scanner (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              clear_scan,
    input  logic [sparse_pkg::CHUNK_SIZE-1:0] filter_map,
    input  logic [sparse_pkg::CHUNK_SIZE-1:0] feature_map,
    input  logic                              ready,
    output logic                              match_valid,
    output logic [sparse_pkg::POS_WIDTH-1:0]  match_pos,
    output logic                              scan_empty
);

    logic [sparse_pkg::CHUNK_SIZE-1:0] work_map;
    logic [sparse_pkg::POS_WIDTH-1:0]  lowest_pos;

    // Lowest set bit wins, scanned from the top down
    always_comb begin
        lowest_pos = '0;
        for (int k = sparse_pkg::CHUNK_SIZE - 1; k >= 0; k--) begin
            if (work_map[k]) begin
                lowest_pos = sparse_pkg::POS_WIDTH'(k);
            end
        end
    end

    assign scan_empty = (work_map == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            work_map    <= '0;
            match_valid <= 1'b0;
            match_pos   <= '0;
        end else if (clear_scan) begin
            work_map    <= filter_map & feature_map;
            match_valid <= 1'b0;
        end else if (ready && !scan_empty) begin
            work_map[lowest_pos] <= 1'b0;
            match_valid          <= 1'b1;
            match_pos            <= lowest_pos;
        end else begin
            // Stall with the map intact while the FIFO is near full
            match_valid <= 1'b0;
        end
    end

endmodule

// File: src/operand_store.sv
`timescale 1ns/1ps

module operand_store (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               load,
    input  sparse_pkg::chunk_t                 chunk_in,
    input  logic [sparse_pkg::POS_WIDTH-1:0]   match_pos,
    output logic [sparse_pkg::CHUNK_SIZE-1:0]  map,
    output logic [sparse_pkg::DATA_WIDTH-1:0]  value
);

    localparam int N      = sparse_pkg::CHUNK_SIZE;
    localparam int LEVELS = sparse_pkg::POS_WIDTH;
    localparam int CW     = sparse_pkg::CNT_WIDTH;

    logic [N-1:0][sparse_pkg::DATA_WIDTH-1:0] values;
    logic [CW-1:0]                            prefix [0:LEVELS][N];
    logic [CW-1:0]                            slot_count;
    logic [CW-1:0]                            slot_index;

    // Operand map captured on load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map <= '0;
        end else if (load) begin
            map <= chunk_in.map;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            values <= chunk_in.values;
        end
    end

    // Level 0 holds the map bits as counts
    genvar i, j;
    generate
        for (i = 0; i < N; i++) begin : g_level0
            assign prefix[0][i] = CW'(map[i]);
        end

        // Each level adds the partial count 2**(j-1) positions below
        for (j = 1; j <= LEVELS; j++) begin : g_level
            for (i = 0; i < N; i++) begin : g_node
                if (i >= (1 << (j - 1))) begin : g_add
                    assign prefix[j][i] = prefix[j-1][i] + prefix[j-1][i - (1 << (j - 1))];
                end else begin : g_pass
                    assign prefix[j][i] = prefix[j-1][i];
                end
            end
        end
    endgenerate

    // Slot is one below the inclusive count at the match position
    assign slot_count = prefix[LEVELS][match_pos];
    assign slot_index = slot_count - 1'b1;
    assign value      = values[slot_index[sparse_pkg::POS_WIDTH-1:0]];

endmodule

// File: src/pair_fifo.sv
`timescale 1ns/1ps

module pair_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  sparse_pkg::pair_t push_pair,
    output logic              ready,
    output logic              empty,
    output logic              pair_valid,
    output sparse_pkg::pair_t pair
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    sparse_pkg::pair_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              pop;

    assign empty = (count == '0);
    assign pop   = !empty;

    // A push already in flight counts against the free space
    assign ready = (int'(count) + int'(push)) < FIFO_DEPTH;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pair;
        end
        if (pop) begin
            pair <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= pop;
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/sparse_dot_unit.sv
`timescale 1ns/1ps

module sparse_dot_unit #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                filter_load,
    input  logic                                feature_load,
    input  logic                                start_compute,
    input  sparse_pkg::chunk_t                  filter_chunk,
    input  sparse_pkg::chunk_t                  feature_chunk,
    output logic                                done_compute,
    output logic [sparse_pkg::ACCUM_WIDTH-1:0]  partial_sum
);

    logic [sparse_pkg::CHUNK_SIZE-1:0] filter_map;
    logic [sparse_pkg::CHUNK_SIZE-1:0] feature_map;
    logic [sparse_pkg::DATA_WIDTH-1:0] filter_value;
    logic [sparse_pkg::DATA_WIDTH-1:0] feature_value;
    logic [sparse_pkg::POS_WIDTH-1:0]  match_pos;
    logic                              match_valid;
    logic                              scan_empty;
    logic                              clear_scan;
    logic                              clear_sum;
    logic                              ready;
    logic                              fifo_empty;
    logic                              pair_valid;
    logic                              mac_busy;
    sparse_pkg::pair_t                 match_pair;
    sparse_pkg::pair_t                 pair;

    // Both lookups index with the same registered match position
    assign match_pair.filter_value  = filter_value;
    assign match_pair.feature_value = feature_value;

    operand_store i_filter_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (filter_load),
        .chunk_in  (filter_chunk),
        .match_pos (match_pos),
        .map       (filter_map),
        .value     (filter_value)
    );

    operand_store i_feature_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (feature_load),
        .chunk_in  (feature_chunk),
        .match_pos (match_pos),
        .map       (feature_map),
        .value     (feature_value)
    );

    match_scanner i_match_scanner (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_scan  (clear_scan),
        .filter_map  (filter_map),
        .feature_map (feature_map),
        .ready       (ready),
        .match_valid (match_valid),
        .match_pos   (match_pos),
        .scan_empty  (scan_empty)
    );

    join_control i_join_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_compute (start_compute),
        .scan_empty    (scan_empty),
        .match_valid   (match_valid),
        .fifo_empty    (fifo_empty),
        .pair_valid    (pair_valid),
        .mac_busy      (mac_busy),
        .clear_scan    (clear_scan),
        .clear_sum     (clear_sum),
        .done_compute  (done_compute)
    );

    pair_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_pair_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (match_valid),
        .push_pair  (match_pair),
        .ready      (ready),
        .empty      (fifo_empty),
        .pair_valid (pair_valid),
        .pair       (pair)
    );

    mac_accumulator i_mac_accumulator (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_sum   (clear_sum),
        .pair_valid  (pair_valid),
        .pair        (pair),
        .partial_sum (partial_sum),
        .mac_busy    (mac_busy)
    );

endmodule

// File: src/sparse_pkg.sv
package sparse_pkg;

    // Chunk geometry
    localparam int CHUNK_SIZE = 16;
    localparam int DATA_WIDTH = 8;
    localparam int ACCUM_WIDTH = 32;

    // Position of one map bit
    localparam int POS_WIDTH = $clog2(CHUNK_SIZE);
    // Inclusive prefix count, 0 up to CHUNK_SIZE
    localparam int CNT_WIDTH = POS_WIDTH + 1;

    // One operand chunk
    // Slot k holds the value of the (k+1)-th set map bit, counted from bit 0
    typedef struct packed {
        logic [CHUNK_SIZE-1:0]                 map;
        logic [CHUNK_SIZE-1:0][DATA_WIDTH-1:0] values;
    } chunk_t;

    // Value pair for one matching map position
    typedef struct packed {
        logic [DATA_WIDTH-1:0] filter_value;
        logic [DATA_WIDTH-1:0] feature_value;
    } pair_t;

    // Control FSM states
    typedef enum logic [1:0] {
        IDLE,
        PROCESS,
        DONE
    } ctrl_state_e;

endpackage

// File: verification/sparse_dot_unit_assert.sv
`timescale 1ns/1ps

module sparse_dot_unit_assert #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start_compute,
    input  logic                               done_compute,
    input  logic [sparse_pkg::ACCUM_WIDTH-1:0] partial_sum,
    input  logic                               push,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]    fifo_count
);

    logic holding;
    // Sticky failure flags, one per property
    logic done_single_failed = 1'b0;
    logic push_full_failed   = 1'b0;
    logic sum_held_failed    = 1'b0;
    logic any_failed;

    assign any_failed = done_single_failed || push_full_failed || sum_held_failed;

    // Result is held from done until the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            holding <= 1'b0;
        end else if (start_compute) begin
            holding <= 1'b0;
        end else if (done_compute) begin
            holding <= 1'b1;
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done_compute |=> !done_compute)
        else begin
            $error("done_compute stayed high for two cycles");
            done_single_failed = 1'b1;
        end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (int'(fifo_count) < FIFO_DEPTH))
        else begin
            $error("pair FIFO pushed while full");
            push_full_failed = 1'b1;
        end

    a_sum_held: assert property (@(posedge clk) disable iff (!rst_n)
        (done_compute || holding) && !start_compute |=> $stable(partial_sum))
        else begin
            $error("partial_sum changed after done_compute");
            sum_held_failed = 1'b1;
        end

endmodule

bind sparse_dot_unit sparse_dot_unit_assert #(
    .FIFO_DEPTH (FIFO_DEPTH)
) i_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_compute (start_compute),
    .done_compute  (done_compute),
    .partial_sum   (partial_sum),
    .push          (match_valid),
    .fifo_count    (i_pair_fifo.count)
);

// File: verification/tb_sparse_dot_unit.sv
`timescale 1ns/1ps

module tb_sparse_dot_unit;

    localparam int FIFO_DEPTH     = 4;
    localparam int N              = sparse_pkg::CHUNK_SIZE;
    localparam int NUM_DIRECTED   = 4;
    localparam int NUM_RANDOM     = 20;
    localparam int NUM_ENTRIES    = NUM_DIRECTED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (4 * N + 20);

    logic                               clk;
    logic                               rst_n;
    logic                               filter_load;
    logic                               feature_load;
    logic                               start_compute;
    sparse_pkg::chunk_t                 filter_chunk;
    sparse_pkg::chunk_t                 feature_chunk;
    logic                               done_compute;
    logic [sparse_pkg::ACCUM_WIDTH-1:0] partial_sum;

    // Stimulus table with expected sums
    sparse_pkg::chunk_t                 filter_tab   [NUM_ENTRIES];
    sparse_pkg::chunk_t                 feature_tab  [NUM_ENTRIES];
    logic [sparse_pkg::ACCUM_WIDTH-1:0] expected_tab [NUM_ENTRIES];
    int                                 cycle_count;

    sparse_dot_unit #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .filter_load   (filter_load),
        .feature_load  (feature_load),
        .start_compute (start_compute),
        .filter_chunk  (filter_chunk),
        .feature_chunk (feature_chunk),
        .done_compute  (done_compute),
        .partial_sum   (partial_sum)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Stops the run once any bound property has failed
    task automatic check_bound_assertions();
        assert (i_dut.i_assert.any_failed === 1'b0) else begin
            $display("A concurrent assertion bound to sparse_dot_unit failed at %0t", $time);
            $display(">>> FAIL");
            $fatal(1, "bound assertion failure");
        end
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            check_bound_assertions();
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles without finishing all entries", cycle_count);
                $display(">>> FAIL");
                $fatal(1, "simulation timed out");
            end
        end
    end

    // Sum of filter times feature value where both map bits are set
    // Value of the k-th set bit lives in slot k-1
    function automatic logic [31:0] reference_dot(input sparse_pkg::chunk_t f,
                                                  input sparse_pkg::chunk_t g);
        int unsigned sum;
        int          f_count;
        int          g_count;
        sum     = 0;
        f_count = 0;
        g_count = 0;
        for (int p = 0; p < N; p++) begin
            f_count += int'(f.map[p]);
            g_count += int'(g.map[p]);
            if (f.map[p] && g.map[p]) begin
                sum += int'(f.values[f_count-1]) * int'(g.values[g_count-1]);
            end
        end
        return sum;
    endfunction

    // About one value in four is the maximum
    function automatic logic [7:0] random_value();
        if ($urandom_range(0, 3) == 0) begin
            return 8'hFF;
        end
        return 8'($urandom_range(0, 255));
    endfunction

    task automatic build_table();
        sparse_pkg::chunk_t f;
        sparse_pkg::chunk_t g;
        // Disjoint maps
        f.map = 16'h00FF;
        g.map = 16'hFF00;
        for (int k = 0; k < N; k++) begin
            f.values[k] = 8'(k + 1);
            g.values[k] = 8'(k + 1);
        end
        filter_tab[0]   = f;
        feature_tab[0]  = g;
        expected_tab[0] = 0;
        // Single overlap at bit 5 with filter slot 2 and feature slot 3
        f.map = 16'h0025;
        g.map = 16'h003A;
        for (int k = 0; k < N; k++) begin
            f.values[k] = 8'(k + 10);
            g.values[k] = 8'(k + 20);
        end
        filter_tab[1]   = f;
        feature_tab[1]  = g;
        expected_tab[1] = 12 * 23;
        // Full maps give 16 matches
        f.map = 16'hFFFF;
        g.map = 16'hFFFF;
        for (int k = 0; k < N; k++) begin
            f.values[k] = 8'(k + 1);
            g.values[k] = 8'(16 - k);
        end
        filter_tab[2]   = f;
        feature_tab[2]  = g;
        expected_tab[2] = 816;
        for (int k = 0; k < N; k++) begin
            f.values[k] = 8'hFF;
            g.values[k] = 8'hFF;
        end
        filter_tab[3]   = f;
        feature_tab[3]  = g;
        expected_tab[3] = 16 * 65025;
        for (int n = NUM_DIRECTED; n < NUM_ENTRIES; n++) begin
            f.map = 16'($urandom);
            g.map = 16'($urandom);
            for (int k = 0; k < N; k++) begin
                f.values[k] = random_value();
                g.values[k] = random_value();
            end
            filter_tab[n]   = f;
            feature_tab[n]  = g;
            expected_tab[n] = reference_dot(f, g);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic run_entry(input int n);
        logic [31:0] held;
        held = (n == 0) ? 32'd0 : expected_tab[n-1];
        filter_chunk = filter_tab[n];
        filter_load  = 1'b1;
        @(posedge clk);
        #1;
        filter_load   = 1'b0;
        feature_chunk = feature_tab[n];
        feature_load  = 1'b1;
        @(posedge clk);
        #1;
        feature_load = 1'b0;
        // Previous result still held before the new start
        check_value("partial_sum", held, partial_sum);
        start_compute = 1'b1;
        @(posedge clk);
        #1;
        start_compute = 1'b0;
        while (done_compute !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        check_value("partial_sum", expected_tab[n], partial_sum);
    endtask

    initial begin
        void'($urandom(32'h06826de9));
        rst_n         = 1'b0;
        filter_load   = 1'b0;
        feature_load  = 1'b0;
        start_compute = 1'b0;
        filter_chunk  = '0;
        feature_chunk = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("done_compute", 32'd0, 32'(done_compute));
        check_value("partial_sum", 32'd0, partial_sum);
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            run_entry(n);
        end
        check_bound_assertions();
        $display(">>> PASS");
        $finish;
    end

endmodule
